/* common/l0_settings.svh */
// l0 cache control settings: queue depths, field widths, init sweep and stall threshold
`ifndef L0_SETTINGS_SVH
`define L0_SETTINGS_SVH

// field widths
`define L0_ADDR_W 37
`define L0_REQ_W 5
`define L0_UNIT_W 5

// queue depths
`define L0_CODE_DEPTH 8
`define L0_MISS_DEPTH 16

`define L0_STALL_CNT 6 // code queue fill level for do_skip
`define L0_INIT_CYCLES 32 // one cycle per miss table entry

`endif

/* common/l0_req_pkg.sv */
// request-side types for the l0 cache control: addresses, queue entries, insert port
`include "l0_settings.svh"

package l0_req_pkg;

  typedef logic [`L0_ADDR_W-1:0] addr_t;
  typedef logic [`L0_REQ_W-1:0] req_id_t;
  typedef logic [`L0_UNIT_W-1:0] unit_id_t;

  typedef struct packed {
    addr_t addr;
    req_id_t req;
    logic dupl;
    logic want_excl;
  } miss_entry_t;

  typedef struct packed {
    addr_t addr;
    req_id_t req;
  } code_entry_t;

  // cache insert port
  typedef struct packed {
    logic valid;
    logic is_code;
    logic second;
    logic dupl;
    req_id_t req;
    addr_t addr;
  } insert_t;

  typedef enum logic {init_sweep, run} init_state_t;

endpackage

/* common/l0_bus_pkg.sv */
// system bus records for the l0 cache control: outgoing request and incoming reply

package l0_bus_pkg;

  // miss request onto the system bus
  typedef struct packed {
    logic used;
    logic code;
    logic want_excl;
    logic dupl;
    l0_req_pkg::unit_id_t src_unit;
    l0_req_pkg::req_id_t src_req;
    l0_req_pkg::addr_t addr;
  } bus_req_t;

  // reply as seen on the reply bus
  typedef struct packed {
    logic used;
    logic mem_reply; // line data from memory
    logic second; // second half of the line
    l0_req_pkg::unit_id_t dst_unit;
    l0_req_pkg::req_id_t dst_req;
  } bus_reply_t;

endpackage

/* verilog/entry_fifo.sv */
// circular entry queue with occupancy count, early head and near-full flag
`timescale 1ns/1ps

module entry_fifo #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 42,
  localparam int CNT_W = $clog2(DEPTH + 1),
  localparam int PTR_W = $clog2(DEPTH)
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  input  logic [CNT_W-1:0] near_full_at,
  output logic [WIDTH-1:0] head,
  output logic             not_empty,
  output logic             near_full
);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic full;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head = mem[rd_ptr];
  assign not_empty = count != '0;
  assign full = count == CNT_W'(DEPTH);
  assign near_full = count >= near_full_at;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  // push into a full queue is fine only when the head leaves at the same edge
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push && !pop |-> !full)
    else $error("entry_fifo: push into full queue");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    pop |-> not_empty)
    else $error("entry_fifo: pop from empty queue");

endmodule

/* miss/miss_table.sv */
// miss table indexed by request number, cleared by a sweep after reset
`timescale 1ns/1ps
`include "l0_settings.svh"

module miss_table (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr_en,
  input  l0_req_pkg::req_id_t  wr_req,
  input  l0_req_pkg::addr_t    wr_addr,
  input  logic                 wr_dupl,
  input  l0_req_pkg::req_id_t  rd_req,
  output l0_req_pkg::addr_t    rd_addr,
  output logic                 rd_dupl,
  output logic                 ready
);

  localparam int TABLE_DEPTH = 1 << `L0_REQ_W;
  localparam int INIT_W = $clog2(`L0_INIT_CYCLES);

  l0_req_pkg::addr_t addr_mem [TABLE_DEPTH];
  logic dupl_mem [TABLE_DEPTH];

  l0_req_pkg::init_state_t state;
  logic [INIT_W-1:0] init_cnt;
  l0_req_pkg::req_id_t rd_idx;

  logic we;
  l0_req_pkg::req_id_t wa;
  l0_req_pkg::addr_t wd_addr;
  logic wd_dupl;

  // sweep owns the write port until run
  always_comb begin
    if (state == l0_req_pkg::init_sweep) begin
      we = 1'b1;
      wa = l0_req_pkg::req_id_t'(init_cnt);
      wd_addr = '0;
      wd_dupl = 1'b0;
    end else begin
      we = wr_en;
      wa = wr_req;
      wd_addr = wr_addr;
      wd_dupl = wr_dupl;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= l0_req_pkg::init_sweep;
      init_cnt <= '0;
      rd_idx <= '0;
    end else begin
      rd_idx <= rd_req; // read data trails by one cycle
      if (state == l0_req_pkg::init_sweep) begin
        init_cnt <= init_cnt + 1'b1;
        if (init_cnt == INIT_W'(`L0_INIT_CYCLES - 1)) state <= l0_req_pkg::run;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      addr_mem[wa] <= wd_addr;
      dupl_mem[wa] <= wd_dupl;
    end
  end

  assign rd_addr = addr_mem[rd_idx];
  assign rd_dupl = dupl_mem[rd_idx];
  assign ready = state == l0_req_pkg::run;

  // requester has to wait for ready before recording misses
  a_no_early_miss: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> state == l0_req_pkg::run)
    else $error("miss_table: miss written during init sweep");

endmodule

/* miss/miss_issue.sv */
// miss queue and system bus request issue under the want/can handshake
`timescale 1ns/1ps
`include "l0_settings.svh"

module miss_issue #(
  parameter l0_req_pkg::unit_id_t UNIT_ID = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    miss_en,
  input  l0_req_pkg::miss_entry_t miss_in,
  input  logic                    bus_can,
  output logic                    bus_want,
  output l0_bus_pkg::bus_req_t    bus_req
);

  localparam int MISS_CNT_W = $clog2(`L0_MISS_DEPTH + 1);

  l0_req_pkg::miss_entry_t head;
  logic queued;
  logic xfer;

  entry_fifo #(
    .DEPTH(`L0_MISS_DEPTH),
    .WIDTH($bits(l0_req_pkg::miss_entry_t))
  ) i_miss_queue (
    .clk(clk),
    .rst(rst),
    .push(miss_en),
    .push_data(miss_in),
    .pop(xfer),
    .near_full_at(MISS_CNT_W'(`L0_MISS_DEPTH)),
    .head(head),
    .not_empty(queued),
    .near_full()
  );

  assign bus_want = queued;
  assign xfer = bus_want && bus_can; // head leaves at this edge

  always_comb begin
    bus_req.used = xfer;
    bus_req.code = head.req[4] && !head.req[3]; // instruction-side request numbers
    bus_req.want_excl = head.want_excl;
    bus_req.dupl = head.dupl;
    bus_req.src_unit = UNIT_ID;
    bus_req.src_req = head.req;
    bus_req.addr = head.addr;
  end

endmodule

/* verilog/insert_arbiter.sv */
// reply register and match, fill versus code choice for the cache insert port
`timescale 1ns/1ps

module insert_arbiter #(
  parameter l0_req_pkg::unit_id_t UNIT_ID = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  l0_bus_pkg::bus_reply_t  reply,
  input  l0_req_pkg::addr_t       fill_addr,
  input  logic                    fill_dupl,
  input  l0_req_pkg::code_entry_t code_head,
  input  logic                    code_ready,
  output logic                    code_pop,
  output l0_req_pkg::insert_t     ins
);

  l0_bus_pkg::bus_reply_t reply_q;
  logic fill;

  // lines the reply up with the table read data
  always_ff @(posedge clk) begin
    if (rst) begin
      reply_q <= '0;
    end else begin
      reply_q <= reply;
    end
  end

  assign fill = reply_q.used && reply_q.mem_reply && reply_q.dst_unit == UNIT_ID;
  assign code_pop = code_ready && !fill; // fill owns the port

  always_comb begin
    ins.valid = fill || code_pop;
    ins.is_code = code_pop;
    if (fill) begin
      ins.second = reply_q.second;
      ins.dupl = fill_dupl;
      ins.req = reply_q.dst_req;
      ins.addr = fill_addr;
    end else begin
      ins.second = 1'b0;
      ins.dupl = 1'b0;
      ins.req = code_head.req;
      ins.addr = code_head.addr;
    end
  end

  // a code insert never takes a cycle that belongs to a reply from the previous cycle
  a_fill_beats_code: assert property (@(posedge clk) disable iff (rst)
    code_pop && !$past(rst) |->
      !$past(reply.used && reply.mem_reply && reply.dst_unit == UNIT_ID))
    else $error("insert_arbiter: code insert collided with a fill");

endmodule

/* verilog/l0_cntrl_top.sv */
// l0 data cache control top: miss queue and table, reply fills, code queue
`timescale 1ns/1ps
`include "l0_settings.svh"

module l0_cntrl_top #(
  parameter l0_req_pkg::unit_id_t UNIT_ID = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    code_en,
  input  l0_req_pkg::code_entry_t code_in,
  input  logic                    miss_en,
  input  l0_req_pkg::miss_entry_t miss_in,
  input  logic                    bus_can,
  input  l0_bus_pkg::bus_reply_t  reply,
  output logic                    bus_want,
  output l0_bus_pkg::bus_req_t    bus_req,
  output l0_req_pkg::insert_t     ins,
  output logic                    do_skip,
  output logic                    ready
);

  localparam int CODE_CNT_W = $clog2(`L0_CODE_DEPTH + 1);

  l0_req_pkg::code_entry_t code_head;
  logic code_ready;
  logic code_pop;
  l0_req_pkg::addr_t fill_addr;
  logic fill_dupl;

  entry_fifo #(
    .DEPTH(`L0_CODE_DEPTH),
    .WIDTH($bits(l0_req_pkg::code_entry_t))
  ) i_code_queue (
    .clk(clk),
    .rst(rst),
    .push(code_en),
    .push_data(code_in),
    .pop(code_pop),
    .near_full_at(CODE_CNT_W'(`L0_STALL_CNT)),
    .head(code_head),
    .not_empty(code_ready),
    .near_full(do_skip) // stall warning to the requester
  );

  miss_table i_miss_table (
    .clk(clk),
    .rst(rst),
    .wr_en(miss_en),
    .wr_req(miss_in.req),
    .wr_addr(miss_in.addr),
    .wr_dupl(miss_in.dupl),
    .rd_req(reply.dst_req),
    .rd_addr(fill_addr),
    .rd_dupl(fill_dupl),
    .ready(ready)
  );

  miss_issue #(.UNIT_ID(UNIT_ID)) i_miss_issue (
    .clk(clk),
    .rst(rst),
    .miss_en(miss_en),
    .miss_in(miss_in),
    .bus_can(bus_can),
    .bus_want(bus_want),
    .bus_req(bus_req)
  );

  insert_arbiter #(.UNIT_ID(UNIT_ID)) i_insert_arbiter (
    .clk(clk),
    .rst(rst),
    .reply(reply),
    .fill_addr(fill_addr),
    .fill_dupl(fill_dupl),
    .code_head(code_head),
    .code_ready(code_ready),
    .code_pop(code_pop),
    .ins(ins)
  );

endmodule

/* bench/tb_clk_gen.sv */
// testbench clock and reset source, 20 ns period with reset held for a few cycles
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD = 10,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0; // released on a rising edge like the stimulus
  end

endmodule

/* bench/l0_checker.sv */
// watcher for the l0 cache control: expected queues for bus requests and inserts
`timescale 1ns/1ps
`include "l0_settings.svh"

module l0_checker #(
  parameter l0_req_pkg::unit_id_t UNIT_ID = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    code_en,
  input  l0_req_pkg::code_entry_t code_in,
  input  logic                    miss_en,
  input  l0_req_pkg::miss_entry_t miss_in,
  input  logic                    bus_can,
  input  logic                    bus_want,
  input  l0_bus_pkg::bus_req_t    bus_req,
  input  l0_req_pkg::insert_t     ins,
  input  logic                    do_skip,
  input  logic                    ready,
  input  l0_req_pkg::insert_t     exp_fill, // from the reference function
  output int                      errors,
  output int                      pending
);

  l0_req_pkg::miss_entry_t miss_q[$];
  l0_req_pkg::code_entry_t code_q[$];
  int since_rst;
  logic ready_late;

  task automatic compare_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] got_v);
    if (exp_v !== got_v) begin
      $display("CHECK FAILED %s expected %h got %h at %0t", name, exp_v, got_v, $time);
      errors++;
    end
  endtask

  task automatic report(input string what);
    $display("ERROR: %s at %0t", what, $time);
    errors++;
  endtask

  function automatic l0_bus_pkg::bus_req_t issue_rule(input l0_req_pkg::miss_entry_t m);
    l0_bus_pkg::bus_req_t r;
    r.used = 1'b1;
    r.code = m.req[4] && !m.req[3];
    r.want_excl = m.want_excl;
    r.dupl = m.dupl;
    r.src_unit = UNIT_ID;
    r.src_req = m.req;
    r.addr = m.addr;
    return r;
  endfunction

  initial begin
    errors = 0;
    pending = 0;
    since_rst = 0;
    ready_late = 1'b0;
  end

  always @(posedge clk) begin
    l0_req_pkg::insert_t exp_code;
    if (rst) begin
      miss_q.delete();
      code_q.delete();
      since_rst = 0;
    end else begin
      if (since_rst == 0) begin
        compare_value("ready", 64'(1'b0), 64'(ready));
        compare_value("bus_want", 64'(1'b0), 64'(bus_want));
        compare_value("ins.valid", 64'(1'b0), 64'(ins.valid));
        compare_value("do_skip", 64'(1'b0), 64'(do_skip));
      end
      if (!ready && !ready_late && since_rst >= `L0_INIT_CYCLES + 2) begin
        report("ready did not rise after the init sweep");
        ready_late = 1'b1;
      end
      // miss issue
      compare_value("bus_want", 64'(miss_q.size() != 0), 64'(bus_want));
      if (bus_req.used) begin
        if (!bus_can) report("bus request sent without bus_can");
        if (miss_q.size() == 0) begin
          report("bus request with no queued miss");
        end else begin
          compare_value("bus_req", 64'(issue_rule(miss_q[0])), 64'(bus_req));
          void'(miss_q.pop_front());
        end
      end else if (bus_can && miss_q.size() != 0) begin
        report("queued miss not sent while bus_can high");
      end
      // insert port, fill first
      compare_value("do_skip", 64'(code_q.size() >= `L0_STALL_CNT), 64'(do_skip));
      if (exp_fill.valid) begin
        compare_value("ins", 64'(exp_fill), 64'(ins));
      end else if (code_q.size() != 0) begin
        exp_code = '0;
        exp_code.valid = 1'b1;
        exp_code.is_code = 1'b1;
        exp_code.req = code_q[0].req;
        exp_code.addr = code_q[0].addr;
        if (!ins.valid) report("code insert missing");
        else compare_value("ins", 64'(exp_code), 64'(ins));
        void'(code_q.pop_front());
      end else if (ins.valid) begin
        report("insert with nothing expected");
      end
      if (miss_en) miss_q.push_back(miss_in);
      if (code_en) code_q.push_back(code_in);
      since_rst++;
    end
    pending = miss_q.size() + code_q.size();
  end

endmodule

/* bench/l0_cntrl_tb.sv */
// testbench top for the l0 cache control: stimulus, reference model and timeout
`timescale 1ns/1ps
`include "l0_settings.svh"

module l0_cntrl_tb;

  localparam l0_req_pkg::unit_id_t MY_UNIT = 5'd3;
  localparam int N_MISS = 12;
  localparam int N_REPLY = 30;
  localparam int N_FLOOD = 12;
  localparam int STIM_ITEMS = 1 + N_MISS + N_REPLY + N_FLOOD;
  localparam int CYCLE_LIMIT = `L0_INIT_CYCLES + 40 * STIM_ITEMS;

  logic clk;
  logic rst;
  logic code_en;
  l0_req_pkg::code_entry_t code_in;
  logic miss_en;
  l0_req_pkg::miss_entry_t miss_in;
  logic bus_can;
  l0_bus_pkg::bus_reply_t reply;
  logic bus_want;
  l0_bus_pkg::bus_req_t bus_req;
  l0_req_pkg::insert_t ins;
  logic do_skip;
  logic ready;
  int errors;
  int pending;
  int cycles;
  integer seed;
  logic can_random; // bus_can follows $random when set

  // reference copy of the miss table and the registered reply
  l0_req_pkg::addr_t tbl_addr [32];
  logic tbl_dupl [32];
  l0_bus_pkg::bus_reply_t reply_q;
  l0_req_pkg::insert_t exp_fill;

  tb_clk_gen i_clk_gen (.clk(clk), .rst(rst));

  l0_cntrl_top #(.UNIT_ID(MY_UNIT)) i_l0_cntrl_top (
    .clk(clk), .rst(rst), .code_en(code_en), .code_in(code_in),
    .miss_en(miss_en), .miss_in(miss_in), .bus_can(bus_can), .reply(reply),
    .bus_want(bus_want), .bus_req(bus_req), .ins(ins), .do_skip(do_skip), .ready(ready)
  );

  l0_checker #(.UNIT_ID(MY_UNIT)) i_checker (
    .clk(clk), .rst(rst), .code_en(code_en), .code_in(code_in),
    .miss_en(miss_en), .miss_in(miss_in), .bus_can(bus_can), .bus_want(bus_want),
    .bus_req(bus_req), .ins(ins), .do_skip(do_skip), .ready(ready),
    .exp_fill(exp_fill), .errors(errors), .pending(pending)
  );

  function automatic l0_req_pkg::insert_t expect_insert(input l0_bus_pkg::bus_reply_t r,
                                                        input l0_req_pkg::addr_t a,
                                                        input logic d);
    l0_req_pkg::insert_t e;
    e = '0;
    if (r.used && r.mem_reply && r.dst_unit == MY_UNIT) begin
      e.valid = 1'b1;
      e.second = r.second;
      e.dupl = d;
      e.req = r.dst_req;
      e.addr = a;
    end
    return e;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      reply_q <= '0;
      for (int i = 0; i < 32; i++) begin
        tbl_addr[i] <= '0; // sweep clears every entry
        tbl_dupl[i] <= 1'b0;
      end
    end else begin
      reply_q <= reply;
      if (miss_en) begin
        tbl_addr[miss_in.req] <= miss_in.addr;
        tbl_dupl[miss_in.req] <= miss_in.dupl;
      end
    end
  end

  always_comb exp_fill = expect_insert(reply_q, tbl_addr[reply_q.dst_req],
                                       tbl_dupl[reply_q.dst_req]);

  always @(posedge clk) begin
    if (can_random) bus_can <= $random(seed) % 2 != 0;
    else bus_can <= 1'b1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d events still pending", cycles, pending);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic idle_inputs;
    miss_en <= 1'b0;
    code_en <= 1'b0;
    reply <= '0;
  endtask

  task automatic random_reply(input logic flood);
    l0_bus_pkg::bus_reply_t r;
    r = l0_bus_pkg::bus_reply_t'($random(seed));
    if (flood || $random(seed) % 2 != 0) r.dst_unit = MY_UNIT; // aimed at us
    if (flood) begin
      r.used = 1'b1;
      r.mem_reply = 1'b1;
    end
    reply <= r;
  endtask

  task automatic maybe_code;
    l0_req_pkg::code_entry_t c;
    c.addr = l0_req_pkg::addr_t'({$random(seed), $random(seed)});
    c.req = l0_req_pkg::req_id_t'($random(seed));
    code_en <= !do_skip && $random(seed) % 2 != 0;
    code_in <= c;
  endtask

  initial begin
    l0_req_pkg::miss_entry_t m;
    seed = 32'h841eb9b7;
    cycles = 0;
    can_random = 1'b0;
    bus_can = 1'b0;
    code_en = 1'b0;
    code_in = '0;
    miss_en = 1'b0;
    miss_in = '0;
    reply = '0;
    @(negedge rst);
    while (!ready) @(posedge clk);
    // reply to a request number never written
    @(posedge clk);
    reply <= '{used: 1'b1, mem_reply: 1'b1, second: 1'b0, dst_unit: MY_UNIT, dst_req: 5'd7};
    @(posedge clk);
    idle_inputs();
    can_random <= 1'b1;
    for (int i = 0; i < N_MISS; i++) begin
      m = l0_req_pkg::miss_entry_t'({$random(seed), $random(seed)});
      @(posedge clk);
      miss_en <= 1'b1;
      miss_in <= m;
      @(posedge clk);
      miss_en <= 1'b0;
    end
    for (int i = 0; i < N_REPLY; i++) begin
      @(posedge clk);
      random_reply(1'b0);
      maybe_code();
    end
    // fills own the insert port, code reads pile up
    for (int i = 0; i < N_FLOOD; i++) begin
      @(posedge clk);
      random_reply(1'b1);
      code_en <= !do_skip;
      code_in <= l0_req_pkg::code_entry_t'({$random(seed), $random(seed)});
    end
    @(posedge clk);
    idle_inputs();
    while (pending != 0 || bus_want) @(posedge clk);
    repeat (4) @(posedge clk);
    @(negedge clk); // last edge's checks have settled
    $display("errors: %0d check failures, %0d events missing", errors, pending);
    if (errors == 0 && pending == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+common
common/l0_req_pkg.sv
common/l0_bus_pkg.sv
verilog/entry_fifo.sv
miss/miss_table.sv
miss/miss_issue.sv
verilog/insert_arbiter.sv
verilog/l0_cntrl_top.sv
bench/tb_clk_gen.sv
bench/l0_checker.sv
bench/l0_cntrl_tb.sv

/* Bender.yml */
package:
  name: l0_cntrl

sources:
  - include_dirs:
      - common
    files:
      - common/l0_req_pkg.sv
      - common/l0_bus_pkg.sv
      - verilog/entry_fifo.sv
      - miss/miss_table.sv
      - miss/miss_issue.sv
      - verilog/insert_arbiter.sv
      - verilog/l0_cntrl_top.sv
      - target: test
        include_dirs:
          - common
        files:
          - bench/tb_clk_gen.sv
          - bench/l0_checker.sv
          - bench/l0_cntrl_tb.sv
